// File: common/batchFilter_defines.svh
`ifndef BATCH_FILTER_DEFINES_SVH
`define BATCH_FILTER_DEFINES_SVH

// Samples per batch
`define BATCH_DEPTH 8

// One-bit samples packed into each input word
`define DSR 4

// Pole at COEF_NUM / 2**COEF_SHIFT
`define COEF_NUM 15
`define COEF_SHIFT 4

// Recursion state and output widths
`define ACC_WIDTH 12
`define OUT_WIDTH 8

// Output buffer entries
`define FIFO_DEPTH 4

`endif

// File: common/batchFilterPkg.sv
`include "batchFilter_defines.svh"

package batchFilterPkg;

    // Raw input word, one bit per sample
    typedef logic [`DSR-1:0] inWord_t;

    // Decoded sample, range -DSR..DSR
    typedef logic signed [3:0] sample_t;

    typedef logic signed [`ACC_WIDTH-1:0] acc_t;

    typedef logic [$clog2(`BATCH_DEPTH)-1:0] batchIdx_t;

    // Four rotating slots in the sample memory
    typedef logic [1:0] sampleSlot_t;
    typedef logic [$bits(sampleSlot_t)+$bits(batchIdx_t)-1:0] sampleAddr_t;

    // Parity slot plus index for the result memories
    typedef logic [$bits(batchIdx_t):0] resAddr_t;

    // One recursion step: scale by the pole, floor, then add the sample
    function automatic acc_t recStep(input acc_t state, input sample_t sample);
        logic signed [`ACC_WIDTH+5:0] scaled;
        scaled = state * `COEF_NUM;
        // Arithmetic shift rounds toward minus infinity
        scaled = scaled >>> `COEF_SHIFT;
        return acc_t'(scaled + sample);
    endfunction

endpackage

// File: common/ramPortIf.sv
`timescale 1ns/1ps

interface ramPortIf #(
    parameter type payload_t = logic,
    parameter type addr_t = logic [4:0],
    parameter int NumRead = 1
) ();

    logic wrEn;
    addr_t wrAddr;
    payload_t wrData;

    // Read enable is shared by all read ports
    logic rdEn;
    addr_t rdAddr [NumRead];
    payload_t rdData [NumRead];

    modport owner (
        output wrEn, wrAddr, wrData, rdEn, rdAddr,
        input rdData
    );

    modport memory (
        input wrEn, wrAddr, wrData, rdEn, rdAddr,
        output rdData
    );

    // Split owner for memories written and read by different blocks
    modport writer (
        output wrEn, wrAddr, wrData
    );

    modport reader (
        output rdEn, rdAddr,
        input rdData
    );

endinterface

// File: hw/batchRam.sv
`timescale 1ns/1ps

module batchRam #(
    parameter type payload_t = logic,
    parameter int Depth = 32,
    parameter int NumRead = 1
) (
    input logic clkDS,
    ramPortIf.memory port
);

    payload_t mem [Depth];

    always_ff @(posedge clkDS) begin
        if (port.wrEn) begin
            mem[port.wrAddr] <= port.wrData;
        end
    end

    // Registered reads, held while rdEn is low
    for (genvar r = 0; r < NumRead; r++) begin : gRead
        always_ff @(posedge clkDS) begin
            if (port.rdEn) begin
                // Bypass so a same-address write is seen at once
                if (port.wrEn && (port.wrAddr == port.rdAddr[r])) begin
                    port.rdData[r] <= port.wrData;
                end else begin
                    port.rdData[r] <= mem[port.rdAddr[r]];
                end
            end
        end
    end

endmodule

// File: hw/batchSequencer.sv
`timescale 1ns/1ps
`include "batchFilter_defines.svh"

module batchSequencer (
    input logic clkDS,
    input logic rst,
    input logic inValid,
    input batchFilterPkg::inWord_t inBits,
    input logic fifoFull,
    output logic inReady,
    output logic tick,
    output logic periodStart,
    output logic primed,
    ramPortIf.owner sampleBus,
    ramPortIf.writer fwdWr,
    ramPortIf.writer backWr,
    output batchFilterPkg::sample_t lookSample,
    output batchFilterPkg::sample_t backSample,
    output batchFilterPkg::sample_t fwdSample,
    input batchFilterPkg::acc_t fwdState,
    input batchFilterPkg::acc_t backState
);
    import batchFilterPkg::*;

    localparam batchIdx_t LastIdx = batchIdx_t'(`BATCH_DEPTH - 1);

    batchIdx_t idx;
    batchIdx_t idxRev;
    sampleSlot_t slot;
    logic lastIdx;

    // Periods seen since reset, saturating at four
    logic [2:0] warm;

    // Copies delayed by one tick, aligned with the read data
    batchIdx_t idxD;
    batchIdx_t idxRevD;
    logic parityD;
    logic lookLive;
    logic histLive;

    logic [$clog2(`DSR+1)-1:0] ones;
    sample_t decoded;

    assign inReady = ~fifoFull;
    assign tick = inValid & inReady;
    assign lastIdx = (idx == LastIdx);

    // Decoded value is 2 * ones - DSR
    always_comb begin
        ones = '0;
        for (int i = 0; i < `DSR; i++) begin
            ones = ones + inBits[i];
        end
        decoded = sample_t'(2 * ones - `DSR);
    end

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            idx <= '0;
            idxRev <= LastIdx;
            slot <= '0;
            warm <= '0;
            idxD <= '0;
            idxRevD <= '0;
            parityD <= 1'b0;
            periodStart <= 1'b0;
            lookLive <= 1'b0;
            histLive <= 1'b0;
            primed <= 1'b0;
        end else if (tick) begin
            idx <= lastIdx ? '0 : idx + 1'b1;
            idxRev <= lastIdx ? LastIdx : idxRev - 1'b1;
            if (lastIdx) begin
                slot <= slot + 1'b1;
                if (warm != 3'd4) begin
                    warm <= warm + 1'b1;
                end
            end
            idxD <= idx;
            idxRevD <= idxRev;
            // Results of period c go to parity (c - 3) mod 2
            parityD <= ~slot[0];
            periodStart <= (idx == '0);
            // Slot c-1 holds data from period one on, slot c-3 from period three
            lookLive <= (warm >= 3'd1);
            histLive <= (warm >= 3'd3);
            // First set by the tick that reads period 4, index 0
            if (warm == 3'd4) begin
                primed <= 1'b1;
            end
        end
    end

    // Incoming word into slot c mod 4
    assign sampleBus.wrEn = tick;
    assign sampleBus.wrAddr = {slot, idx};
    assign sampleBus.wrData = decoded;

    // Port 0 lookahead, port 1 backward, port 2 forward
    assign sampleBus.rdEn = tick;
    assign sampleBus.rdAddr[0] = {sampleSlot_t'(slot - 2'd1), idxRev};
    assign sampleBus.rdAddr[1] = {sampleSlot_t'(slot - 2'd3), idxRev};
    assign sampleBus.rdAddr[2] = {sampleSlot_t'(slot - 2'd3), idx};

    // Slots not yet written after reset read as zero
    assign lookSample = lookLive ? sampleBus.rdData[0] : '0;
    assign backSample = histLive ? sampleBus.rdData[1] : '0;
    assign fwdSample = histLive ? sampleBus.rdData[2] : '0;

    // New states are written on the tick they are computed
    assign fwdWr.wrEn = tick;
    assign fwdWr.wrAddr = {parityD, idxD};
    assign fwdWr.wrData = fwdState;

    assign backWr.wrEn = tick;
    assign backWr.wrAddr = {parityD, idxRevD};
    assign backWr.wrData = backState;

endmodule

// File: recursion/recursionBank.sv
`timescale 1ns/1ps

module recursionBank (
    input logic clkDS,
    input logic rst,
    input logic tick,
    input logic periodStart,
    input batchFilterPkg::sample_t lookSample,
    input batchFilterPkg::sample_t backSample,
    input batchFilterPkg::sample_t fwdSample,
    output batchFilterPkg::acc_t fwdState,
    output batchFilterPkg::acc_t backState
);
    import batchFilterPkg::*;

    acc_t lookReg;
    acc_t backReg;
    acc_t fwdReg;
    acc_t lookNext;
    acc_t backNext;
    acc_t fwdNext;

    // periodStart arrives already delayed to match the samples
    always_comb begin
        lookNext = recStep(periodStart ? acc_t'(0) : lookReg, lookSample);
        // Lookahead of the previous period seeds the backward pass
        backNext = recStep(periodStart ? lookReg : backReg, backSample);
        fwdNext = recStep(fwdReg, fwdSample);
    end

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            lookReg <= '0;
            backReg <= '0;
            fwdReg <= '0;
        end else if (tick) begin
            lookReg <= lookNext;
            backReg <= backNext;
            fwdReg <= fwdNext;
        end
    end

    // Next states go straight to the result memories
    assign fwdState = fwdNext;
    assign backState = backNext;

endmodule

// File: hw/batchCombiner.sv
`timescale 1ns/1ps
`include "batchFilter_defines.svh"

module batchCombiner (
    input logic clkDS,
    input logic rst,
    input logic tick,
    input logic primed,
    ramPortIf.reader fwdRd,
    ramPortIf.reader backRd,
    output logic outValid,
    input logic outReady,
    output logic [`OUT_WIDTH-1:0] outData,
    output logic fifoFull
);
    import batchFilterPkg::*;

    localparam int PtrWidth = $clog2(`FIFO_DEPTH);
    localparam int CntWidth = $clog2(`FIFO_DEPTH + 1);
    localparam logic signed [`ACC_WIDTH:0] OutMax = 2 ** (`OUT_WIDTH - 1) - 1;
    localparam logic signed [`ACC_WIDTH:0] OutMin = -(2 ** (`OUT_WIDTH - 1));

    // Own read position, period c reads parity c mod 2
    batchIdx_t rdIdx;
    logic rdParity;

    logic signed [`ACC_WIDTH:0] sumReg;
    logic sumVld;
    logic signed [`ACC_WIDTH:0] clamped;
    logic [`OUT_WIDTH-1:0] outWord;

    logic [`OUT_WIDTH-1:0] fifoMem [`FIFO_DEPTH];
    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth-1:0] rdPtr;
    logic [CntWidth-1:0] count;
    logic push;
    logic pop;

    assign fwdRd.rdEn = tick;
    assign fwdRd.rdAddr[0] = {rdParity, rdIdx};
    assign backRd.rdEn = tick;
    assign backRd.rdAddr[0] = {rdParity, rdIdx};

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            rdIdx <= '0;
            rdParity <= 1'b0;
            sumVld <= 1'b0;
        end else if (tick) begin
            rdIdx <= rdIdx + 1'b1;
            if (rdIdx == batchIdx_t'(`BATCH_DEPTH - 1)) begin
                rdIdx <= '0;
                rdParity <= ~rdParity;
            end
            sumVld <= primed;
        end
    end

    always_ff @(posedge clkDS) begin
        if (tick) begin
            sumReg <= fwdRd.rdData[0] + backRd.rdData[0];
        end
    end

    // Saturate, then flip the sign bit for offset binary
    always_comb begin
        if (sumReg > OutMax) begin
            clamped = OutMax;
        end else if (sumReg < OutMin) begin
            clamped = OutMin;
        end else begin
            clamped = sumReg;
        end
        outWord = {~clamped[`OUT_WIDTH-1], clamped[`OUT_WIDTH-2:0]};
    end

    // A tick only happens while the FIFO has room
    assign push = tick & sumVld;
    assign pop = outValid & outReady;

    always_ff @(posedge clkDS) begin
        if (push) begin
            fifoMem[wrPtr] <= outWord;
        end
    end

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + CntWidth'(push) - CntWidth'(pop);
        end
    end

    assign outValid = (count != '0);
    assign fifoFull = (count == CntWidth'(`FIFO_DEPTH));
    assign outData = fifoMem[rdPtr];

endmodule

// File: hw/batchFilterTop.sv
`timescale 1ns/1ps
`include "batchFilter_defines.svh"

module batchFilterTop (
    input logic clkDS,
    input logic rst,
    input logic inValid,
    input batchFilterPkg::inWord_t inBits,
    output logic inReady,
    output logic outValid,
    output logic [`OUT_WIDTH-1:0] outData,
    input logic outReady
);
    import batchFilterPkg::*;

    logic tick;
    logic periodStart;
    logic primed;
    logic fifoFull;
    sample_t lookSample;
    sample_t backSample;
    sample_t fwdSample;
    acc_t fwdState;
    acc_t backState;

    // Four sample slots, two result parity slots
    ramPortIf #(.payload_t(sample_t), .addr_t(sampleAddr_t), .NumRead(3)) sampleBus ();
    ramPortIf #(.payload_t(acc_t), .addr_t(resAddr_t), .NumRead(1)) fwdBus ();
    ramPortIf #(.payload_t(acc_t), .addr_t(resAddr_t), .NumRead(1)) backBus ();

    batchSequencer sequencer (
        .clkDS(clkDS),
        .rst(rst),
        .inValid(inValid),
        .inBits(inBits),
        .fifoFull(fifoFull),
        .inReady(inReady),
        .tick(tick),
        .periodStart(periodStart),
        .primed(primed),
        .sampleBus(sampleBus.owner),
        .fwdWr(fwdBus.writer),
        .backWr(backBus.writer),
        .lookSample(lookSample),
        .backSample(backSample),
        .fwdSample(fwdSample),
        .fwdState(fwdState),
        .backState(backState)
    );

    recursionBank recursion (
        .clkDS(clkDS),
        .rst(rst),
        .tick(tick),
        .periodStart(periodStart),
        .lookSample(lookSample),
        .backSample(backSample),
        .fwdSample(fwdSample),
        .fwdState(fwdState),
        .backState(backState)
    );

    batchCombiner combiner (
        .clkDS(clkDS),
        .rst(rst),
        .tick(tick),
        .primed(primed),
        .fwdRd(fwdBus.reader),
        .backRd(backBus.reader),
        .outValid(outValid),
        .outReady(outReady),
        .outData(outData),
        .fifoFull(fifoFull)
    );

    batchRam #(.payload_t(sample_t), .Depth(4 * `BATCH_DEPTH), .NumRead(3)) sampleRam (
        .clkDS(clkDS),
        .port(sampleBus.memory)
    );

    batchRam #(.payload_t(acc_t), .Depth(2 * `BATCH_DEPTH), .NumRead(1)) fwdRam (
        .clkDS(clkDS),
        .port(fwdBus.memory)
    );

    batchRam #(.payload_t(acc_t), .Depth(2 * `BATCH_DEPTH), .NumRead(1)) backRam (
        .clkDS(clkDS),
        .port(backBus.memory)
    );

endmodule

// File: tb/batchFilter_props.sv
`timescale 1ns/1ps
`include "batchFilter_defines.svh"

module batchFilterProps (
    input logic clkDS,
    input logic rst,
    input logic outValid,
    input logic outReady,
    input logic [`OUT_WIDTH-1:0] outData,
    input logic inReady,
    input logic fifoFull
);

    // Failed assertions so far
    int failCount = 0;

    // Output handshake is idle during reset
    assert property (@(posedge clkDS) !rst |-> !outValid)
        else begin
            $error("outValid is high while rst is low");
            failCount++;
        end

    // A stalled word must not change
    assert property (@(posedge clkDS) disable iff (!rst)
        (outValid && !outReady) |=> $stable(outData))
        else begin
            $error("outData changed while stalled");
            failCount++;
        end

    // Input is accepted whenever the output FIFO has room
    assert property (@(posedge clkDS) disable iff (!rst)
        inReady == !fifoFull)
        else begin
            $error("inReady does not follow the FIFO full flag");
            failCount++;
        end

endmodule

bind batchFilterTop batchFilterProps props (
    .clkDS(clkDS),
    .rst(rst),
    .outValid(outValid),
    .outReady(outReady),
    .outData(outData),
    .inReady(inReady),
    .fifoFull(fifoFull)
);

// File: tb/batchFilterTb.sv
`timescale 1ns/1ps
`include "batchFilter_defines.svh"

module batchFilterTb;

    localparam int NumTests = 7;
    localparam int ResetCycles = 5;
    localparam int StallLimit = 200;
    localparam int DrainLimit = 500;
    localparam int Latency = 4 * `BATCH_DEPTH + 2;
    localparam int Mid = 1 << (`OUT_WIDTH - 1);
    localparam int PatRandom = 0;
    localparam int PatOnes = 1;
    localparam int PatZeros = 2;
    localparam int PatAlt = 3;

    // Expected side of the last output relative to the midpoint (0 skips the check)
    typedef struct packed {
        int batches;
        int pattern;
        int validPct;
        int readyPct;
        int preWords;
        int expCount;
        int side;
    } testRow_t;

    logic clkDS;
    logic rst;
    logic inValid;
    logic [`DSR-1:0] inBits;
    logic inReady;
    logic outValid;
    logic [`OUT_WIDTH-1:0] outData;
    logic outReady;

    testRow_t rows [NumTests];
    string names [NumTests];
    logic [`DSR-1:0] wordQ [$];
    int sampleQ [$];
    int expQ [$];
    int errCount = 0;
    int checkCount = 0;
    int outCount = 0;
    int lastOut = 0;
    int readyPct = 100;
    int failedTests = 0;
    int seedVal;
    int t;
    bit hung = 1'b0;

    batchFilterTop i_batchFilterTop (
        .clkDS(clkDS),
        .rst(rst),
        .inValid(inValid),
        .inBits(inBits),
        .inReady(inReady),
        .outValid(outValid),
        .outData(outData),
        .outReady(outReady)
    );

    initial begin
        clkDS = 1'b0;
        forever #20 clkDS = ~clkDS;
    end

    task automatic checkValue(input string sigName, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            $display("FAIL %0t %s got %0d expected %0d", $time, sigName, got, exp);
            errCount++;
        end
    endtask

    // Value mismatches and timeouts plus failed bound assertions
    function automatic int totalErrors();
        return errCount + i_batchFilterTop.props.failCount;
    endfunction

    function automatic int decodeWord(input logic [`DSR-1:0] word);
        int ones;
        ones = 0;
        for (int i = 0; i < `DSR; i++) begin
            ones += word[i];
        end
        return 2 * ones - `DSR;
    endfunction

    function automatic int poleStep(input int state, input int smp);
        int divisor;
        int prod;
        int quot;
        divisor = 1 << `COEF_SHIFT;
        prod = state * `COEF_NUM;
        quot = prod / divisor;
        // Division truncates, so step down on a negative remainder
        if (prod % divisor != 0 && prod < 0) begin
            quot = quot - 1;
        end
        return quot + smp;
    endfunction

    function automatic int offsetBinary(input int value);
        int v;
        v = value;
        if (v > Mid - 1) begin
            v = Mid - 1;
        end else if (v < -Mid) begin
            v = -Mid;
        end
        return v + Mid;
    endfunction

    // Reference outputs for every sample the pipeline will emit
    task automatic buildExpected(input int numWords);
        int numOut;
        int fwd;
        int look;
        int back;
        int n;
        int bk [`BATCH_DEPTH];
        numOut = numWords - Latency;
        fwd = 0;
        for (int b = 0; b * `BATCH_DEPTH < numOut; b++) begin
            look = 0;
            for (int k = `BATCH_DEPTH - 1; k >= 0; k--) begin
                look = poleStep(look, sampleQ[(b + 1) * `BATCH_DEPTH + k]);
            end
            back = look;
            for (int k = `BATCH_DEPTH - 1; k >= 0; k--) begin
                back = poleStep(back, sampleQ[b * `BATCH_DEPTH + k]);
                bk[k] = back;
            end
            for (int k = 0; k < `BATCH_DEPTH; k++) begin
                n = b * `BATCH_DEPTH + k;
                if (n < numOut) begin
                    fwd = poleStep(fwd, sampleQ[n]);
                    expQ.push_back(offsetBinary(fwd + bk[k]));
                end
            end
        end
    endtask

    task automatic applyReset();
        @(posedge clkDS);
        rst <= 1'b0;
        inValid <= 1'b0;
        repeat (ResetCycles) @(posedge clkDS);
        rst <= 1'b1;
    endtask

    // Offer words with the given duty, holding each until it is taken
    task automatic driveWords(input int validPct);
        int idx;
        int waitCycles;
        logic accepted;
        idx = 0;
        waitCycles = 0;
        while (idx < wordQ.size() && !hung) begin
            @(posedge clkDS);
            accepted = inValid && inReady;
            if (accepted) begin
                idx++;
                waitCycles = 0;
            end else begin
                waitCycles++;
            end
            if (idx >= wordQ.size()) begin
                inValid <= 1'b0;
            end else if (!inValid || accepted) begin
                inValid <= (($urandom % 100) < validPct);
                inBits <= wordQ[idx];
            end
            if (waitCycles > StallLimit) begin
                $display("Timeout at %0t: input word %0d was never accepted", $time, idx);
                errCount++;
                hung = 1'b1;
                inValid <= 1'b0;
            end
        end
    endtask

    task automatic runStream(input int numWords, input int pattern, input int validPct);
        logic [`DSR-1:0] word;
        wordQ.delete();
        sampleQ.delete();
        for (int i = 0; i < numWords; i++) begin
            case (pattern)
                PatOnes: word = '1;
                PatZeros: word = '0;
                PatAlt: word = (i % 2 == 0) ? '1 : '0;
                default: word = $urandom % (1 << `DSR);
            endcase
            wordQ.push_back(word);
            sampleQ.push_back(decodeWord(word));
        end
        buildExpected(numWords);
        driveWords(validPct);
    endtask

    task automatic waitDrain();
        int cycles;
        cycles = 0;
        while ((expQ.size() != 0 || outValid) && !hung) begin
            @(negedge clkDS);
            cycles++;
            if (cycles > DrainLimit) begin
                $display("Timeout at %0t: %0d expected output words never arrived",
                         $time, expQ.size());
                errCount++;
                hung = 1'b1;
            end
        end
    endtask

    task automatic runTest(input int idx);
        int errsBefore;
        int outsBefore;
        errsBefore = totalErrors();
        readyPct = rows[idx].readyPct;
        applyReset();
        @(negedge clkDS);
        checkValue("outValid", outValid, 0);
        checkValue("inReady", inReady, 1);
        if (rows[idx].preWords > 0) begin
            runStream(rows[idx].preWords, PatRandom, rows[idx].validPct);
            waitDrain();
            // Restart in the middle of a batch
            applyReset();
        end
        outsBefore = outCount;
        runStream(rows[idx].batches * `BATCH_DEPTH, rows[idx].pattern, rows[idx].validPct);
        waitDrain();
        checkValue("output count", outCount - outsBefore, rows[idx].expCount);
        if (rows[idx].side != 0) begin
            checkValue("last outData above midpoint", lastOut > Mid, rows[idx].side > 0);
        end
        if (totalErrors() != errsBefore) begin
            failedTests++;
        end
        $display("Test %0d %s: %0d outputs, %0d errors", idx, names[idx],
                 outCount - outsBefore, totalErrors() - errsBefore);
    endtask

    // Output monitor and random outReady
    always @(posedge clkDS) begin
        int expWord;
        outReady <= (($urandom % 100) < readyPct);
        if (rst && outValid && outReady) begin
            if (expQ.size() == 0) begin
                $display("Unexpected output word %0d at %0t with nothing left to expect",
                         outData, $time);
                errCount++;
            end else begin
                expWord = expQ.pop_front();
                checkValue("outData", outData, expWord);
                outCount++;
                lastOut = outData;
            end
        end
    end

    initial begin
        seedVal = $urandom(24);
        rst = 1'b0;
        inValid = 1'b0;
        inBits = '0;
        outReady = 1'b0;
        rows[0] = '{8, PatRandom, 100, 100, 0, 30, 0};
        names[0] = "random, ready high";
        rows[1] = '{10, PatOnes, 100, 100, 0, 46, 1};
        names[1] = "all ones";
        rows[2] = '{10, PatZeros, 100, 100, 0, 46, -1};
        names[2] = "all zeros";
        rows[3] = '{9, PatRandom, 100, 35, 0, 38, 0};
        names[3] = "output back-pressure";
        rows[4] = '{9, PatRandom, 45, 100, 0, 38, 0};
        names[4] = "input gaps";
        rows[5] = '{7, PatRandom, 70, 70, 45, 22, 0};
        names[5] = "reset mid-stream";
        rows[6] = '{8, PatAlt, 60, 60, 0, 30, 0};
        names[6] = "alternating, both duties";
        t = 0;
        while (t < NumTests && !hung) begin
            runTest(t);
            t++;
        end
        $display("Tests run %0d, tests failed %0d, outputs %0d, checks %0d, errors %0d",
                 t, failedTests, outCount, checkCount, totalErrors());
        if (totalErrors() == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+common
common/batchFilterPkg.sv
common/ramPortIf.sv
hw/batchRam.sv
hw/batchSequencer.sv
recursion/recursionBank.sv
hw/batchCombiner.sv
hw/batchFilterTop.sv
tb/batchFilter_props.sv
tb/batchFilterTb.sv
